// ==== verilog/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

	localparam int CYCLES_PER_US = 2;	// one clock rate only

	// initialisation waits and enable pulse, in microseconds
	localparam int T_POWERUP_US = 500;
	localparam int T_CMD_US = 50;
	localparam int T_CLEAR_US = 200;
	localparam int T_ENTRY_US = 100;
	localparam int T_E_PULSE_US = 10;

	// write cycle timing, in microseconds
	localparam int T_WRITE_US = 50;
	localparam int T_SETUP_US = 1;		// address setup before e rises
	localparam int T_E_HIGH_US = 13;

	localparam int LINE_CHARS = 16;
	localparam int NUM_LINES = 2;
	localparam logic [6:0] LINE2_ADDR = 7'h40;	// ddram base of line 2
	localparam logic [7:0] BLANK_CHAR = 8'h20;

	// bus controller cycle counts, derived from the times above
	localparam int BUS_CNT_W = 10;
	localparam logic [BUS_CNT_W-1:0] PWR_CYC = BUS_CNT_W'(T_POWERUP_US * CYCLES_PER_US);
	localparam logic [BUS_CNT_W-1:0] PULSE_CYC = BUS_CNT_W'(T_E_PULSE_US * CYCLES_PER_US);
	localparam logic [BUS_CNT_W-1:0] DISP_OFS =
		BUS_CNT_W'((T_E_PULSE_US + T_CMD_US) * CYCLES_PER_US);
	localparam logic [BUS_CNT_W-1:0] CLR_OFS =
		BUS_CNT_W'(2 * (T_E_PULSE_US + T_CMD_US) * CYCLES_PER_US);
	localparam logic [BUS_CNT_W-1:0] ENTRY_OFS =
		CLR_OFS + BUS_CNT_W'((T_E_PULSE_US + T_CLEAR_US) * CYCLES_PER_US);
	localparam logic [BUS_CNT_W-1:0] INIT_CYC =
		ENTRY_OFS + BUS_CNT_W'((T_E_PULSE_US + T_ENTRY_US) * CYCLES_PER_US);
	localparam logic [BUS_CNT_W-1:0] WR_CYC = BUS_CNT_W'(T_WRITE_US * CYCLES_PER_US);
	localparam logic [BUS_CNT_W-1:0] SETUP_CYC = BUS_CNT_W'(T_SETUP_US * CYCLES_PER_US);
	localparam logic [BUS_CNT_W-1:0] E_HIGH_CYC = BUS_CNT_W'(T_E_HIGH_US * CYCLES_PER_US);

	typedef enum logic [7:0] {
		CMD_CLEAR     = 8'h01,
		CMD_ENTRY     = 8'h04,
		CMD_DISPLAY   = 8'h08,
		CMD_FUNCTION  = 8'h20,
		CMD_SET_DDRAM = 8'h80
	} lcd_cmd_e;

	typedef enum logic [1:0] {POWER_UP, INIT, IDLE, WRITE} bus_state_e;

	typedef enum logic [1:0] {WAIT_DIRTY, SEND_ADDR, SEND_CHAR} refresh_state_e;

endpackage

`default_nettype wire

// ==== verilog/text_buffer.sv ====
`default_nettype none

module text_buffer (
	input  logic       clk,
	input  logic       rst,
	input  logic       req,
	input  logic [4:0] addr,
	input  logic [7:0] wdata,
	output logic       ack,
	input  logic [4:0] rd_addr,
	output logic [7:0] rd_data,
	input  logic       clear_line,
	input  logic       line_sel,
	output logic [1:0] dirty
);

	logic [7:0] mem [lcd_pkg::NUM_LINES * lcd_pkg::LINE_CHARS];
	logic       wr_en;

	assign wr_en = req & ~ack;		// first cycle of a request only
	assign rd_data = mem[rd_addr];

	// four-phase slave, ack follows req one cycle later
	always_ff @(posedge clk) begin
		if (rst)
			ack <= 1'b0;
		else if (req && !ack)
			ack <= 1'b1;
		else if (!req && ack)
			ack <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < lcd_pkg::NUM_LINES * lcd_pkg::LINE_CHARS; i++)
				mem[i] <= lcd_pkg::BLANK_CHAR;		// screen starts blank
		end else if (wr_en) begin
			mem[addr] <= wdata;
		end
	end

	// a write beats a clear of the same line
	always_ff @(posedge clk) begin
		if (rst) begin
			dirty <= '1;		// show the blanks after init
		end else begin
			for (int i = 0; i < lcd_pkg::NUM_LINES; i++) begin
				if (wr_en && addr[4] == 1'(i))
					dirty[i] <= 1'b1;
				else if (clear_line && line_sel == 1'(i))
					dirty[i] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/screen_refresh.sv ====
`default_nettype none

module screen_refresh (
	input  logic       clk,
	input  logic       rst,
	input  logic [1:0] dirty,
	output logic       clear_line,
	output logic       line_sel,
	output logic [4:0] rd_addr,
	input  logic [7:0] rd_data,
	output logic       cmd_valid,
	output logic [9:0] cmd,
	input  logic       busy
);

	lcd_pkg::refresh_state_e state;
	logic       line_q;
	logic [3:0] col;
	logic       accept;

	assign accept = cmd_valid & ~busy;
	assign clear_line = (state == lcd_pkg::WAIT_DIRTY) && (|dirty);
	assign line_sel = (state == lcd_pkg::WAIT_DIRTY) ? ~dirty[0] : line_q;
	assign rd_addr = {line_q, col};
	assign cmd_valid = (state != lcd_pkg::WAIT_DIRTY);

	always_comb begin
		if (state == lcd_pkg::SEND_CHAR)
			cmd = {2'b10, rd_data};
		else
			cmd = {2'b00, lcd_pkg::CMD_SET_DDRAM | {1'b0, (line_q ? lcd_pkg::LINE2_ADDR : 7'h00)}};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= lcd_pkg::WAIT_DIRTY;
			line_q <= 1'b0;
			col <= '0;
		end else begin
			case (state)
				lcd_pkg::WAIT_DIRTY: begin
					if (|dirty) begin
						line_q <= ~dirty[0];
						col <= '0;
						state <= lcd_pkg::SEND_ADDR;
					end
				end
				lcd_pkg::SEND_ADDR: begin
					if (accept)
						state <= lcd_pkg::SEND_CHAR;
				end
				default: begin
					if (accept) begin
						col <= col + 1'b1;
						if (col == 4'(lcd_pkg::LINE_CHARS - 1))
							state <= lcd_pkg::WAIT_DIRTY;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/lcd_bus_ctrl.sv ====
`default_nettype none

module lcd_bus_ctrl (
	input  logic       clk,
	input  logic       rst,
	input  logic [6:0] cfg,
	input  logic       cmd_valid,
	input  logic [9:0] cmd,
	output logic       busy,
	output logic       e,
	output logic [7:0] lcd_data,
	output logic       rs,
	output logic       rw
);

	lcd_pkg::bus_state_e state, state_n;
	logic [lcd_pkg::BUS_CNT_W-1:0] cnt, cnt_n;
	logic [9:0] cmd_q;		// command of the running write
	logic [9:0] wr_word;
	logic [7:0] fn_byte, disp_byte, entry_byte;
	logic       e_n, rs_n, rw_n;
	logic [7:0] data_n;

	// cfg bits sit where the controller expects them
	assign fn_byte = lcd_pkg::CMD_FUNCTION | 8'h10 | {4'b0000, cfg[6:5], 2'b00};	// 8-bit bus
	assign disp_byte = lcd_pkg::CMD_DISPLAY | {5'b00000, cfg[4:2]};
	assign entry_byte = lcd_pkg::CMD_ENTRY | {6'b000000, cfg[1:0]};

	assign busy = (state != lcd_pkg::IDLE);

	// the accepted word is not in cmd_q yet during the acceptance cycle
	assign wr_word = (state == lcd_pkg::IDLE) ? cmd : cmd_q;

	always_comb begin
		state_n = state;
		cnt_n = cnt + 1'b1;
		case (state)
			lcd_pkg::POWER_UP: begin
				if (cnt == lcd_pkg::PWR_CYC - 1'b1) begin
					state_n = lcd_pkg::INIT;
					cnt_n = '0;
				end
			end
			lcd_pkg::INIT: begin
				if (cnt == lcd_pkg::INIT_CYC - 1'b1) begin
					state_n = lcd_pkg::IDLE;
					cnt_n = '0;
				end
			end
			lcd_pkg::IDLE: begin
				cnt_n = '0;
				if (cmd_valid)		// accept the offered command
					state_n = lcd_pkg::WRITE;
			end
			default: begin		// write, acceptance cycle counts as the first
				if (cnt == lcd_pkg::WR_CYC - 2'd2) begin
					state_n = lcd_pkg::IDLE;
					cnt_n = '0;
				end
			end
		endcase
	end

	// pin values for the next cycle, registered below
	always_comb begin
		e_n = 1'b0;
		rs_n = 1'b0;
		rw_n = 1'b0;
		data_n = 8'h00;
		case (state_n)
			lcd_pkg::INIT: begin
				if (cnt_n < lcd_pkg::PULSE_CYC) begin
					e_n = 1'b1;
					data_n = fn_byte;
				end else if (cnt_n >= lcd_pkg::DISP_OFS &&
						cnt_n < lcd_pkg::DISP_OFS + lcd_pkg::PULSE_CYC) begin
					e_n = 1'b1;
					data_n = disp_byte;
				end else if (cnt_n >= lcd_pkg::CLR_OFS &&
						cnt_n < lcd_pkg::CLR_OFS + lcd_pkg::PULSE_CYC) begin
					e_n = 1'b1;
					data_n = lcd_pkg::CMD_CLEAR;
				end else if (cnt_n >= lcd_pkg::ENTRY_OFS &&
						cnt_n < lcd_pkg::ENTRY_OFS + lcd_pkg::PULSE_CYC) begin
					e_n = 1'b1;
					data_n = entry_byte;
				end
			end
			lcd_pkg::WRITE: begin
				rs_n = wr_word[9];		// held for the whole cycle
				rw_n = wr_word[8];
				data_n = wr_word[7:0];
				e_n = (cnt_n >= lcd_pkg::SETUP_CYC) &&
					(cnt_n < lcd_pkg::SETUP_CYC + lcd_pkg::E_HIGH_CYC);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= lcd_pkg::POWER_UP;
			cnt <= '0;
			e <= 1'b0;
			rs <= 1'b0;
			rw <= 1'b0;
			lcd_data <= 8'h00;
		end else begin
			state <= state_n;
			cnt <= cnt_n;
			e <= e_n;
			rs <= rs_n;
			rw <= rw_n;
			lcd_data <= data_n;
		end
	end

	always_ff @(posedge clk) begin
		if (state == lcd_pkg::IDLE && cmd_valid)
			cmd_q <= cmd;
	end

endmodule

`default_nettype wire

// ==== verilog/lcd_text_top.sv ====
`default_nettype none

module lcd_text_top (
	input  logic       clk,
	input  logic       rst,
	input  logic [6:0] cfg,
	input  logic       req,
	input  logic [4:0] addr,
	input  logic [7:0] wdata,
	output logic       ack,
	output logic       e,
	output logic [7:0] lcd_data,
	output logic       rs,
	output logic       rw
);

	logic [1:0] dirty;
	logic       clear_line;
	logic       line_sel;
	logic [4:0] rd_addr;
	logic [7:0] rd_data;
	logic       cmd_valid;
	logic [9:0] cmd;
	logic       busy;

	text_buffer u_buffer (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.addr       (addr),
		.wdata      (wdata),
		.ack        (ack),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.clear_line (clear_line),
		.line_sel   (line_sel),
		.dirty      (dirty)
	);

	screen_refresh u_refresh (
		.clk        (clk),
		.rst        (rst),
		.dirty      (dirty),
		.clear_line (clear_line),
		.line_sel   (line_sel),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.busy       (busy)
	);

	lcd_bus_ctrl u_bus (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.busy      (busy),
		.e         (e),
		.lcd_data  (lcd_data),
		.rs        (rs),
		.rw        (rw)
	);

endmodule

`default_nettype wire

// ==== bench/lcd_monitor.sv ====
`default_nettype none

module lcd_monitor (
	input  logic         clk,
	input  logic         rst,
	input  logic [6:0]   cfg,
	input  logic         req,
	input  logic         ack,
	input  logic         e,
	input  logic [7:0]   lcd_data,
	input  logic         rs,
	input  logic         rw,
	input  logic         writes_done,
	input  logic [255:0] expect_screen,
	output logic         screen_checked,
	output int           checks,
	output int           errors,
	output int           handshakes,
	output int           late_pulses
);

	localparam int C = lcd_pkg::CYCLES_PER_US;
	localparam int INIT_HIGH = lcd_pkg::T_E_PULSE_US * C;
	localparam int WR_HIGH = lcd_pkg::T_E_HIGH_US * C;
	localparam int WR_LEN = lcd_pkg::T_WRITE_US * C;
	localparam int QUIET_CYC = 200;

	logic [7:0] ram [128];		// ddram model
	logic [6:0] ddr_addr;
	logic       e_p, req_p, ack_p, rw_p;
	logic       rs_hold, started;
	logic [7:0] data_hold;		// last byte seen while e was high
	int         cyc, hi_len, pulse_idx, first_rise, last_fall, quiet, init_err;

	// hd44780 instruction bits of the four init bytes
	function automatic logic [7:0] init_byte(input int k);
		case (k)
			0: return {3'b001, 1'b1, cfg[6:5], 2'b00};	// 8-bit bus, lines, font
			1: return {5'b00001, cfg[4:2]};
			2: return lcd_pkg::CMD_CLEAR;
			default: return {6'b000001, cfg[1:0]};
		endcase
	endfunction

	// each byte starts after the previous pulse and its execution time
	function automatic int init_offset(input int k);
		int step;
		step = (lcd_pkg::T_E_PULSE_US + lcd_pkg::T_CMD_US) * C;
		case (k)
			1: return step;
			2: return 2 * step;
			default: return 2 * step + (lcd_pkg::T_E_PULSE_US + lcd_pkg::T_CLEAR_US) * C;
		endcase
	endfunction

	task automatic byte_mismatch(input string name, input logic [7:0] got, input logic [7:0] exp);
		errors++;
		$display("ERROR t=%0t %s: got %02h expected %02h", $time, name, got, exp);
	endtask

	task automatic count_mismatch(input string name, input int got, input int exp);
		errors++;
		$display("ERROR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
	endtask

	task automatic plain_error(input string msg);
		errors++;
		$display("error at t=%0t: %s", $time, msg);
	endtask

	task automatic apply_byte(input logic rs_v, input logic [7:0] d);
		if (rs_v) begin
			ram[ddr_addr] = d;
			ddr_addr = ddr_addr + 7'd1;		// address counts up after data
		end else if (d[7]) begin
			ddr_addr = d[6:0];
		end else if (d == lcd_pkg::CMD_CLEAR) begin
			for (int i = 0; i < 128; i++)
				ram[i] = lcd_pkg::BLANK_CHAR;
			ddr_addr = '0;
		end
	endtask

	task automatic on_rise();
		hi_len = 0;
		if (screen_checked) begin
			late_pulses++;
			plain_error("e pulse after the screen was complete and no line was dirty");
		end
		if (pulse_idx == 0) begin
			first_rise = cyc;
			init_err = errors;
			checks++;
			if (cyc <= lcd_pkg::T_POWERUP_US * C)
				plain_error($sformatf("first e pulse only %0d cycles after reset", cyc));
		end
		if (pulse_idx > 0 && pulse_idx < 4 && cyc - first_rise != init_offset(pulse_idx))
			count_mismatch($sformatf("e rise of init byte %0d", pulse_idx),
				cyc - first_rise, init_offset(pulse_idx));
	endtask

	task automatic on_fall();
		checks++;
		if (pulse_idx < 4) begin
			if (hi_len != INIT_HIGH)
				count_mismatch("e high time", hi_len, INIT_HIGH);
			if (rs_hold !== 1'b0)
				plain_error("rs high during an init byte");
			if (data_hold !== init_byte(pulse_idx))
				byte_mismatch($sformatf("lcd_data (init byte %0d)", pulse_idx),
					data_hold, init_byte(pulse_idx));
			if (pulse_idx == 3 && errors == init_err)
				$display("init sequence: ok");
			else if (pulse_idx == 3)
				$display("init sequence: %0d errors", errors - init_err);
		end else begin
			if (hi_len != WR_HIGH)
				count_mismatch("e high time", hi_len, WR_HIGH);
			if (pulse_idx > 4 && cyc - last_fall < WR_LEN)
				plain_error($sformatf("e falling edges only %0d cycles apart", cyc - last_fall));
		end
		apply_byte(rs_hold, data_hold);
		last_fall = cyc;
		pulse_idx++;
	endtask

	task automatic compare_screen();
		int bad;
		logic [6:0] ddr;
		logic [7:0] want;
		bad = 0;
		for (int i = 0; i < 2 * lcd_pkg::LINE_CHARS; i++) begin
			ddr = (i >= lcd_pkg::LINE_CHARS) ?
				lcd_pkg::LINE2_ADDR + 7'(i - lcd_pkg::LINE_CHARS) : 7'(i);
			want = expect_screen[i*8 +: 8];
			if (ram[ddr] !== want) begin
				bad++;
				byte_mismatch($sformatf("ddram[%02h]", ddr), ram[ddr], want);
			end
		end
		checks++;
		screen_checked = 1'b1;
		if (bad == 0)
			$display("screen contents at t=%0t: ok", $time);
		else
			$display("screen contents at t=%0t: %0d wrong characters", $time, bad);
	endtask

	always @(posedge clk) begin
		if (rst) begin
			screen_checked = 1'b0;
			checks = 0;
			errors = 0;
			handshakes = 0;
			late_pulses = 0;
			cyc = 0;
			hi_len = 0;
			pulse_idx = 0;
			first_rise = 0;
			last_fall = 0;
			quiet = 0;
			init_err = 0;
			started = 1'b0;
			e_p = 1'b0;
			req_p = 1'b0;
			ack_p = 1'b0;
			rw_p = 1'b0;
			ddr_addr = '0;
		end else begin
			cyc++;
			if (!started) begin
				started = 1'b1;
				checks++;
				if (ack !== 1'b0)
					plain_error("ack is not low after reset");
			end
			if (ack && !ack_p && !req_p)
				plain_error("ack rose while req was low");
			if (!ack && ack_p) begin
				handshakes++;
				if (req_p)
					plain_error("ack fell while req was still high");
			end
			if (rw && !rw_p)
				plain_error("rw went high");
			if (e && !e_p)
				on_rise();
			if (e) begin
				hi_len++;
				data_hold = lcd_data;
				rs_hold = rs;
			end else if (e_p) begin
				on_fall();
			end
			if (e || !writes_done)
				quiet = 0;
			else
				quiet++;
			if (!screen_checked && quiet == QUIET_CYC)
				compare_screen();
			e_p = e;
			req_p = req;
			ack_p = ack;
			rw_p = rw;
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_lcd_text.sv ====
`default_nettype none

module tb_lcd_text;

	localparam int NROWS = 10;
	localparam int RANDOM = -1;		// hold-off drawn from the lfsr
	localparam int HS_LIMIT = 16;		// cycles per handshake phase
	localparam logic [6:0] CFG = 7'b10_110_10;	// two lines, display and cursor on, increment
	localparam int C = lcd_pkg::CYCLES_PER_US;
	localparam int STARTUP_CYC = C * (lcd_pkg::T_POWERUP_US +
		2 * (lcd_pkg::T_E_PULSE_US + lcd_pkg::T_CMD_US) +
		(lcd_pkg::T_E_PULSE_US + lcd_pkg::T_CLEAR_US) +
		(lcd_pkg::T_E_PULSE_US + lcd_pkg::T_ENTRY_US));
	localparam int SCREEN_CYC = lcd_pkg::NUM_LINES * (lcd_pkg::LINE_CHARS + 1) *
		lcd_pkg::T_WRITE_US * C;		// both lines, 17 commands each
	localparam int TAIL_CYC = SCREEN_CYC;

	// address, character, idle cycles before the write
	int tbl_addr [NROWS] = '{0, 1, 16, 1, 31, 15, 0, 17, 16, 8};
	int tbl_char [NROWS] = '{'h48, 'h69, 'h4c, 'h65, 'h21, 'h5a, 'h68, 'h32, 'h6c, 'h23};
	int tbl_hold [NROWS] = '{0, RANDOM, RANDOM, 0, 400, RANDOM, 2500, RANDOM, 0, RANDOM};

	logic         clk;
	logic         rst;
	logic [6:0]   cfg;
	logic         req;
	logic [4:0]   addr;
	logic [7:0]   wdata;
	logic         ack;
	logic         e;
	logic [7:0]   lcd_data;
	logic         rs;
	logic         rw;
	logic         writes_done;
	logic [255:0] expect_screen;
	logic         screen_checked;
	int           mon_checks, mon_errors, handshakes, late_pulses;
	int           tb_checks, tb_errors;
	logic [7:0]   lfsr_state;

	lcd_text_top DUT (
		.clk      (clk),
		.rst      (rst),
		.cfg      (cfg),
		.req      (req),
		.addr     (addr),
		.wdata    (wdata),
		.ack      (ack),
		.e        (e),
		.lcd_data (lcd_data),
		.rs       (rs),
		.rw       (rw)
	);

	lcd_monitor monitor (
		.clk            (clk),
		.rst            (rst),
		.cfg            (cfg),
		.req            (req),
		.ack            (ack),
		.e              (e),
		.lcd_data       (lcd_data),
		.rs             (rs),
		.rw             (rw),
		.writes_done    (writes_done),
		.expect_screen  (expect_screen),
		.screen_checked (screen_checked),
		.checks         (mon_checks),
		.errors         (mon_errors),
		.handshakes     (handshakes),
		.late_pulses    (late_pulses)
	);

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic draw_holdoff(output int v);
		v = 0;
		for (int b = 0; b < 7; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic build_expected();
		for (int i = 0; i < 32; i++)
			expect_screen[i*8 +: 8] = lcd_pkg::BLANK_CHAR;
		for (int i = 0; i < NROWS; i++)
			expect_screen[tbl_addr[i]*8 +: 8] = 8'(tbl_char[i]);	// last write wins
	endtask

	function automatic int run_limit();
		int total;
		total = STARTUP_CYC + NROWS * SCREEN_CYC + TAIL_CYC + 5000;
		for (int i = 0; i < NROWS; i++)
			total += (tbl_hold[i] == RANDOM) ? 128 : tbl_hold[i];
		return total;
	endfunction

	// four-phase master, called on a falling edge
	task automatic host_write(input logic [4:0] a, input logic [7:0] d, output bit ok);
		int n;
		ok = 1'b1;
		n = 0;
		while (ack && n < HS_LIMIT) begin
			@(negedge clk);
			n++;
		end
		addr = a;
		wdata = d;
		req = 1'b1;
		n = 0;
		while (!ack && n < HS_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!ack)
			ok = 1'b0;
		req = 1'b0;
		n = 0;
		while (ack && n < HS_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (ack)
			ok = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		int limit;
		limit = run_limit();
		repeat (limit) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", limit);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int hold;
		bit ok;
		rst = 1'b1;
		cfg = CFG;
		req = 1'b0;
		addr = '0;
		wdata = '0;
		writes_done = 1'b0;
		tb_checks = 0;
		tb_errors = 0;
		lfsr_state = 8'd10;
		build_expected();
		repeat (16) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < NROWS; i++) begin
			hold = tbl_hold[i];
			if (hold == RANDOM)
				draw_holdoff(hold);
			repeat (hold) @(negedge clk);
			host_write(5'(tbl_addr[i]), 8'(tbl_char[i]), ok);
			tb_checks++;
			if (ok) begin
				$display("write %0d: addr %0d <= %02h after %0d idle cycles, done",
					i, tbl_addr[i], 8'(tbl_char[i]), hold);
			end else begin
				tb_errors++;
				$display("write %0d: handshake to addr %0d never completed", i, tbl_addr[i]);
			end
		end
		writes_done = 1'b1;
		wait (screen_checked);
		repeat (TAIL_CYC) @(negedge clk);
		tb_checks++;
		if (late_pulses == 0)
			$display("bus after refresh: quiet for %0d cycles", TAIL_CYC);
		else
			$display("bus after refresh: %0d unexpected e pulses", late_pulses);
		tb_checks++;
		if (handshakes != NROWS) begin
			tb_errors++;
			$display("ERROR t=%0t handshakes: got %0d expected %0d", $time, handshakes, NROWS);
		end
		$display("checks: %0d, errors: %0d", tb_checks + mon_checks, tb_errors + mon_errors);
		if (tb_errors + mon_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/lcd_pkg.sv
verilog/text_buffer.sv
verilog/screen_refresh.sv
verilog/lcd_bus_ctrl.sv
verilog/lcd_text_top.sv
bench/lcd_monitor.sv
bench/tb_lcd_text.sv

// ==== Makefile ====
TOP = tb_lcd_text

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module lcd_text_top -f sources.f

sim:
	verilator --binary --timing --top-module $(TOP) -f sources.f -o simv
	out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
